/* Bender.yml */
package:
  name: ext_dev

sources:
  # Package first, then the leaf modules and the top level
  - source/ext_dev_pkg.sv
  - source/cnt_reg_if.sv
  - source/gpio_cnt.sv
  - source/cnt_intr_ctrl.sv
  - source/ext_dev_top.sv

  - target: test
    files:
      - testbench/tb_ext_dev_top.sv

/* ext_dev_top.f */
source/ext_dev_pkg.sv
source/cnt_reg_if.sv
source/gpio_cnt.sv
source/cnt_intr_ctrl.sv
source/ext_dev_top.sv
testbench/tb_ext_dev_top.sv

/* source/cnt_intr_ctrl.sv */
// Interrupt collector for the counter bank
// Sticky status bits with write-1-to-clear and a masked interrupt line

module cnt_intr_ctrl
  import ext_dev_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic [NUM_CNT-1:0] done_i,
  input  logic [NUM_CNT-1:0] mask_i,
  input  logic [NUM_CNT-1:0] clr_i,
  output logic [NUM_CNT-1:0] status_o,
  output logic               intr_o
);

  logic [NUM_CNT-1:0] status_q;
  logic [NUM_CNT-1:0] status_d;
  logic               intr_q;

  // A done pulse wins over a clear in the same cycle
  assign status_d = (status_q & ~clr_i) | done_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      status_q <= '0;
    end else begin
      status_q <= status_d;
    end
  end

  // Interrupt follows status by one edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      intr_q <= 1'b0;
    end else begin
      intr_q <= |(status_q & mask_i);
    end
  end

  assign status_o = status_q;
  assign intr_o   = intr_q;

endmodule

/* source/cnt_reg_if.sv */
// Register front end for the counter bank
// Holds control, mask and limit registers and returns a registered response

module cnt_reg_if
  import ext_dev_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [ADDR_W-1:0]              addr_i,
  input  logic [DATA_W-1:0]              wdata_i,
  input  logic [NUM_CNT-1:0][DATA_W-1:0] count_i,
  input  logic [NUM_CNT-1:0]             status_i,
  output logic                           ready_o,
  output logic [DATA_W-1:0]              rdata_o,
  output logic                           error_o,
  output logic [NUM_CNT-1:0]             en_o,
  output logic [NUM_CNT-1:0][DATA_W-1:0] limit_o,
  output logic [NUM_CNT-1:0]             mask_o,
  output logic [NUM_CNT-1:0]             clr_o
);

  reg_idx_e                       idx;
  logic [CNT_SEL_W-1:0]           sel;
  logic                           accept;
  logic                           hit;
  logic [DATA_W-1:0]              rd_val;
  logic [NUM_CNT-1:0]             ctrl_q;
  logic [NUM_CNT-1:0]             mask_q;
  logic [NUM_CNT-1:0][DATA_W-1:0] limit_q;
  logic                           ready_q;
  logic                           error_q;
  logic [DATA_W-1:0]              rdata_q;

  assign idx = reg_idx_e'(addr_i);
  assign sel = addr_i[CNT_SEL_W-1:0];

  // A request is taken only when no response is out
  assign accept = req_i & ~ready_q;

  // Read mux and address decode
  always_comb begin
    hit    = 1'b1;
    rd_val = '0;
    case (idx)
      REG_CTRL:   rd_val = DATA_W'(ctrl_q);
      REG_MASK:   rd_val = DATA_W'(mask_q);
      REG_STATUS: rd_val = DATA_W'(status_i);
      REG_LIMIT0, REG_LIMIT1, REG_LIMIT2, REG_LIMIT3: begin
        rd_val = limit_q[sel];
      end
      REG_COUNT0, REG_COUNT1, REG_COUNT2, REG_COUNT3: begin
        rd_val = count_i[sel];
      end
      default: hit = 1'b0;
    endcase
  end

  // Write-1-to-clear pulse toward the interrupt collector
  assign clr_o = (accept && we_i && idx == REG_STATUS) ? wdata_i[NUM_CNT-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_q  <= '0;
      mask_q  <= '0;
      limit_q <= '0;
    end else if (accept && we_i) begin
      // COUNT and STATUS writes leave these registers alone
      case (idx)
        REG_CTRL: ctrl_q <= wdata_i[NUM_CNT-1:0];
        REG_MASK: mask_q <= wdata_i[NUM_CNT-1:0];
        REG_LIMIT0, REG_LIMIT1, REG_LIMIT2, REG_LIMIT3: begin
          limit_q[sel] <= wdata_i;
        end
        default: ;
      endcase
    end
  end

  // Response handshake
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      ready_q <= accept;
      error_q <= accept & ~hit;
    end
  end

  // Read data, zero outside a read response
  always_ff @(posedge clk_i) begin
    rdata_q <= (accept && !we_i) ? rd_val : '0;
  end

  assign ready_o = ready_q;
  assign error_o = error_q;
  assign rdata_o = rdata_q;
  assign en_o    = ctrl_q;
  assign mask_o  = mask_q;
  assign limit_o = limit_q;

endmodule

/* source/ext_dev_pkg.sv */
// Shared constants and types for the GPIO edge counter bank
// Register map and counter channel state encodings

package ext_dev_pkg;

  // Number of counter channels in the bank
  localparam int unsigned NUM_CNT = 4;

  // Register data width
  localparam int unsigned DATA_W = 32;

  // Word index width on the register port
  localparam int unsigned ADDR_W = 4;

  // Bits needed to select one channel
  localparam int unsigned CNT_SEL_W = $clog2(NUM_CNT);

  // Register map, word indices
  typedef enum logic [ADDR_W-1:0] {
    REG_CTRL   = 4'd0,
    REG_MASK   = 4'd1,
    REG_STATUS = 4'd2,
    REG_LIMIT0 = 4'd4,
    REG_LIMIT1 = 4'd5,
    REG_LIMIT2 = 4'd6,
    REG_LIMIT3 = 4'd7,
    REG_COUNT0 = 4'd8,
    REG_COUNT1 = 4'd9,
    REG_COUNT2 = 4'd10,
    REG_COUNT3 = 4'd11
  } reg_idx_e;

  // Counter channel state
  typedef enum logic {
    CNT_IDLE = 1'b0,
    CNT_RUN  = 1'b1
  } cnt_state_e;

endpackage

/* source/ext_dev_top.sv */
// Top level of the GPIO edge counter bank
// Register front end, counter channels and interrupt collector

module ext_dev_top
  import ext_dev_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_i,
  input  logic               we_i,
  input  logic [ADDR_W-1:0]  addr_i,
  input  logic [DATA_W-1:0]  wdata_i,
  input  logic [NUM_CNT-1:0] gpio_i,
  output logic               ready_o,
  output logic [DATA_W-1:0]  rdata_o,
  output logic               error_o,
  output logic [NUM_CNT-1:0] gpio_o,
  output logic               intr_o
);

  logic [NUM_CNT-1:0]             en;
  logic [NUM_CNT-1:0][DATA_W-1:0] limit;
  logic [NUM_CNT-1:0][DATA_W-1:0] count;
  logic [NUM_CNT-1:0]             done;
  logic [NUM_CNT-1:0]             mask;
  logic [NUM_CNT-1:0]             clr;
  logic [NUM_CNT-1:0]             status;

  cnt_reg_if cnt_reg_if_i (
    .clk_i,
    .reset_i,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .count_i (count),
    .status_i(status),
    .ready_o,
    .rdata_o,
    .error_o,
    .en_o    (en),
    .limit_o (limit),
    .mask_o  (mask),
    .clr_o   (clr)
  );

  // One channel per GPIO pair
  for (genvar k = 0; k < NUM_CNT; k++) begin : gen_cnt
    gpio_cnt gpio_cnt_i (
      .clk_i,
      .reset_i,
      .en_i   (en[k]),
      .limit_i(limit[k]),
      .gpio_i (gpio_i[k]),
      .gpio_o (gpio_o[k]),
      .count_o(count[k]),
      .done_o (done[k])
    );
  end

  cnt_intr_ctrl cnt_intr_ctrl_i (
    .clk_i,
    .reset_i,
    .done_i  (done),
    .mask_i  (mask),
    .clr_i   (clr),
    .status_o(status),
    .intr_o
  );

endmodule

/* source/gpio_cnt.sv */
// One GPIO edge counter channel
// Synchronizer, rising edge detect, limit compare and output toggle

module gpio_cnt
  import ext_dev_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              en_i,
  input  logic [DATA_W-1:0] limit_i,
  input  logic              gpio_i,
  output logic              gpio_o,
  output logic [DATA_W-1:0] count_o,
  output logic              done_o
);

  cnt_state_e        state_q;
  logic              sync1_q;
  logic              sync2_q;
  logic              sync3_q;
  logic              rise_q;
  logic [DATA_W-1:0] count_q;
  logic [DATA_W-1:0] count_inc;
  logic              gpio_q;
  logic              done_q;

  // Two-flop synchronizer, then a registered rising edge pulse
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
      sync3_q <= 1'b0;
      rise_q  <= 1'b0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      sync3_q <= sync2_q;
      rise_q  <= sync2_q & ~sync3_q;
    end
  end

  assign count_inc = count_q + 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= CNT_IDLE;
      count_q <= '0;
      gpio_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        CNT_IDLE: begin
          count_q <= '0;
          if (en_i) state_q <= CNT_RUN;
        end
        CNT_RUN: begin
          if (!en_i) begin
            state_q <= CNT_IDLE;
            count_q <= '0;
          end else if (rise_q) begin
            // Limit of zero keeps counting and never fires
            if (limit_i != '0 && count_inc >= limit_i) begin
              count_q <= '0;
              gpio_q  <= ~gpio_q;
              done_q  <= 1'b1;
            end else begin
              count_q <= count_inc;
            end
          end
        end
        default: state_q <= CNT_IDLE;
      endcase
    end
  end

  assign gpio_o  = gpio_q;
  assign count_o = count_q;
  assign done_o  = done_q;

endmodule

/* testbench/tb_ext_dev_top.sv */
// Self-checking testbench for the GPIO edge counter bank
// Register tasks, GPIO pulse driver, LFSR limits and assertion checks

module tb_ext_dev_top
  import ext_dev_pkg::*;
();

  localparam int unsigned WAIT_MAX = 64;

  logic               clk_i;
  logic               reset_i;
  logic               req_i;
  logic               we_i;
  logic [ADDR_W-1:0]  addr_i;
  logic [DATA_W-1:0]  wdata_i;
  logic [NUM_CNT-1:0] gpio_i;
  logic               ready_o;
  logic [DATA_W-1:0]  rdata_o;
  logic               error_o;
  logic [NUM_CNT-1:0] gpio_o;
  logic               intr_o;

  int unsigned        value_errs;
  int unsigned        proto_errs;
  int unsigned        timeouts;
  logic [31:0]        lfsr;
  logic [31:0]        bits;
  logic [DATA_W-1:0]  rd;
  logic               err;
  logic [DATA_W-1:0]  lim [NUM_CNT];
  logic [NUM_CNT-1:0] exp_status;
  logic [NUM_CNT-1:0] gpio_before;

  ext_dev_top ext_dev_top_i (
    .clk_i,
    .reset_i,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .gpio_i,
    .ready_o,
    .rdata_o,
    .error_o,
    .gpio_o,
    .intr_o
  );

  always #20 clk_i = ~clk_i;

  // Response is a single-cycle pulse and carries any error
  assert property (@(posedge clk_i) disable iff (reset_i) ready_o |=> !ready_o)
    else begin
      proto_errs++;
      $display("ready_o stayed high for more than one cycle");
    end
  assert property (@(posedge clk_i) disable iff (reset_i) error_o |-> ready_o)
    else begin
      proto_errs++;
      $display("error_o was raised outside a response cycle");
    end

  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_val(input string name, input logic [DATA_W-1:0] exp,
                           input logic [DATA_W-1:0] act);
    assert (act === exp) else begin
      value_errs++;
      $display("Error %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    end
  endtask

  // One request cycle, then wait for the ready pulse
  task automatic reg_access(input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data,
                            output logic [DATA_W-1:0] rdata, output logic resp_err);
    int n;
    @(posedge clk_i);
    #5;
    req_i   = 1'b1;
    we_i    = wr;
    addr_i  = addr;
    wdata_i = data;
    n = 0;
    do begin
      @(posedge clk_i);
      #5;
      req_i = 1'b0;
      n++;
    end while (ready_o !== 1'b1 && n < WAIT_MAX);
    if (ready_o !== 1'b1) begin
      timeouts++;
      $display("Timeout: no ready_o for the access to index %0d", addr);
    end
    rdata    = rdata_o;
    resp_err = error_o;
  endtask

  task automatic write_reg(input string name, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] r;
    logic              e;
    reg_access(1'b1, addr, data, r, e);
    check_val({name, " error_o"}, '0, DATA_W'(e));
  endtask

  task automatic check_read(input string name, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] exp);
    logic [DATA_W-1:0] r;
    logic              e;
    reg_access(1'b0, addr, '0, r, e);
    check_val(name, exp, r);
    check_val({name, " error_o"}, '0, DATA_W'(e));
  endtask

  task automatic wait_gpio(input int k, input logic exp);
    int n;
    n = 0;
    while (gpio_o[k] !== exp && n < WAIT_MAX) begin
      @(posedge clk_i);
      #5;
      n++;
    end
    if (gpio_o[k] !== exp) begin
      timeouts++;
      $display("Timeout: gpio_o[%0d] never became %0b", k, exp);
    end
  endtask

  task automatic wait_intr(input logic exp);
    int n;
    n = 0;
    while (intr_o !== exp && n < WAIT_MAX) begin
      @(posedge clk_i);
      #5;
      n++;
    end
    if (intr_o !== exp) begin
      timeouts++;
      $display("Timeout: intr_o never became %0b", exp);
    end
  endtask

  // High for three cycles, then low for at least three, on every selected input
  task automatic pulse_gpio(input logic [NUM_CNT-1:0] sel, input int n);
    repeat (n) begin
      @(posedge clk_i);
      #5;
      gpio_i = sel;
      repeat (3) @(posedge clk_i);
      #5;
      gpio_i = '0;
      repeat (3) @(posedge clk_i);
    end
  endtask

  initial begin
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    req_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    gpio_i     = '0;
    value_errs = 0;
    proto_errs = 0;
    timeouts   = 0;
    lfsr       = 32'h9767_6d80;
    repeat (5) @(posedge clk_i);
    #5;
    reset_i = 1'b0;

    // Reset state
    check_val("reset outputs", '0, DATA_W'({ready_o, error_o, intr_o, gpio_o}));
    for (int i = 0; i < 12; i++) begin
      if (i != 3) check_read($sformatf("reset read %0d", i), ADDR_W'(i), '0);
    end

    // Register readback and decode errors
    write_reg("mask", REG_MASK, 32'ha);
    check_read("readback MASK", REG_MASK, 32'ha);
    write_reg("ctrl", REG_CTRL, 32'h5);
    check_read("readback CTRL", REG_CTRL, 32'h5);
    write_reg("ctrl off", REG_CTRL, '0);
    for (int k = 0; k < NUM_CNT; k++) begin
      write_reg("limit", ADDR_W'(REG_LIMIT0 + k), 32'h1234_5670 + k);
      check_read("readback LIMIT", ADDR_W'(REG_LIMIT0 + k), 32'h1234_5670 + k);
    end
    reg_access(1'b0, 4'd3, '0, rd, err);
    check_val("unmapped read 3 error_o", 1, DATA_W'(err));
    check_val("unmapped read 3 rdata", '0, rd);
    reg_access(1'b0, 4'd15, '0, rd, err);
    check_val("unmapped read 15 error_o", 1, DATA_W'(err));
    check_val("unmapped read 15 rdata", '0, rd);
    reg_access(1'b1, 4'd13, 32'hffff_ffff, rd, err);
    check_val("unmapped write 13 error_o", 1, DATA_W'(err));
    check_val("unmapped write 13 rdata", '0, rd);

    // Counting below the limit, disabled channel, disable clears
    take_bits(3, bits);
    lim[0] = bits + 2;
    write_reg("limit ch0", REG_LIMIT0, lim[0]);
    write_reg("enable ch0", REG_CTRL, 32'h1);
    pulse_gpio(4'b0011, lim[0] - 1);
    check_read("count below limit", REG_COUNT0, lim[0] - 1);
    check_read("count disabled ch1", REG_COUNT1, '0);
    write_reg("write COUNT0", REG_COUNT0, 32'hff);
    check_read("count after write", REG_COUNT0, lim[0] - 1);
    write_reg("disable ch0", REG_CTRL, '0);
    check_read("count after disable", REG_COUNT0, '0);
    check_read("status without fire", REG_STATUS, '0);

    // Limit reached, masked and unmasked interrupts, write-1-to-clear
    take_bits(3, bits);
    lim[2] = bits + 2;
    take_bits(3, bits);
    lim[3] = bits + 2;
    write_reg("limit ch2", REG_LIMIT2, lim[2]);
    write_reg("limit ch3", REG_LIMIT3, lim[3]);
    write_reg("mask ch2", REG_MASK, 32'h4);
    write_reg("enable ch2 ch3", REG_CTRL, 32'hc);
    pulse_gpio(4'b0100, lim[2]);
    wait_gpio(2, 1'b1);
    check_read("count wrapped ch2", REG_COUNT2, '0);
    check_read("status ch2", REG_STATUS, 32'h4);
    wait_intr(1'b1);
    write_reg("status write 0", REG_STATUS, '0);
    check_read("status kept", REG_STATUS, 32'h4);
    write_reg("status clear ch2", REG_STATUS, 32'h4);
    check_read("status cleared", REG_STATUS, '0);
    wait_intr(1'b0);
    pulse_gpio(4'b1000, lim[3]);
    wait_gpio(3, 1'b1);
    check_read("status ch3", REG_STATUS, 32'h8);
    check_val("intr unmasked ch3", '0, DATA_W'(intr_o));
    pulse_gpio(4'b0100, lim[2]);
    wait_gpio(2, 1'b0);
    check_read("status ch2 ch3", REG_STATUS, 32'hc);
    wait_intr(1'b1);
    write_reg("status clear all", REG_STATUS, 32'hf);
    check_read("status all cleared", REG_STATUS, '0);
    wait_intr(1'b0);

    // All channels pulsed together, each with its own limit
    write_reg("ctrl off", REG_CTRL, '0);
    write_reg("mask all", REG_MASK, 32'hf);
    for (int k = 0; k < NUM_CNT; k++) begin
      take_bits(3, bits);
      lim[k] = bits + 2;
      write_reg("limit", ADDR_W'(REG_LIMIT0 + k), lim[k]);
    end
    write_reg("enable all", REG_CTRL, 32'hf);
    // Channel 3 fired once and channel 2 twice so far
    gpio_before = 4'b1000;
    check_val("gpio before all", DATA_W'(gpio_before), DATA_W'(gpio_o));
    pulse_gpio(4'hf, 7);
    for (int k = 0; k < NUM_CNT; k++) begin
      exp_status[k] = (lim[k] <= 7);
    end
    if (exp_status != '0) wait_intr(1'b1);
    check_read("status all channels", REG_STATUS, DATA_W'(exp_status));
    for (int k = 0; k < NUM_CNT; k++) begin
      check_read($sformatf("count ch%0d", k), ADDR_W'(REG_COUNT0 + k), 7 % lim[k]);
      check_val($sformatf("gpio ch%0d", k), DATA_W'(gpio_before[k] ^ ((7 / lim[k]) % 2)),
                DATA_W'(gpio_o[k]));
    end

    $display("Errors: %0d value, %0d protocol, %0d timeout", value_errs, proto_errs, timeouts);
    if (value_errs == 0 && proto_errs == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
